//--- flist.f
+incdir+logic
logic/fixed_point_pkg.sv
logic/layer_ctrl_pkg.sv
logic/mac_bus_if.sv
logic/weight_rom.sv
logic/mac.sv
logic/squeeze_ctrl.sv
logic/requant_relu.sv
logic/squeeze_layer.sv
verification/squeeze_layer_tb.sv

//--- logic/fixed_point_pkg.sv
`default_nettype none

`include "squeeze_defines.svh"

package fixed_point_pkg;

	// feature value on ifm and ofm
	typedef logic signed [`PIX_W-1:0] pix_t;

	typedef logic signed [`WGT_W-1:0] wgt_t;

	// wide enough for TAPS full-scale products plus the bias
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic signed [`ACC_W-1:0] bias_t;

endpackage

`default_nettype wire

//--- logic/layer_ctrl_pkg.sv
`default_nettype none

`include "squeeze_defines.svh"

package layer_ctrl_pkg;

	typedef enum logic [1:0] {IDLE, RUN, DONE} ctrl_state_t;

	// tap counter runs 0 to TAPS, the last value being the spare slot
	typedef logic [$clog2(`TAPS + 1)-1:0] tap_cnt_t;
	typedef logic [$clog2(`WOUT * `WOUT + 2)-1:0] pix_cnt_t;

endpackage

`default_nettype wire

//--- logic/mac.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

module mac (
	input wire clk,
	input wire rst,
	mac_bus_if.mac bus,
	input wire logic [$clog2(`DSP_NO)-1:0] idx,
	output fixed_point_pkg::acc_t acc
);
	import fixed_point_pkg::*;

	acc_t prod;

	// both operands are sign extended first so the product is exact
	assign prod = acc_t'(bus.pix) * acc_t'(bus.ker[idx]);

	// clr restarts the sum with the current product, otherwise add.
	// nothing moves while layer_en is low, which is how pauses hold
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			acc <= '0;
		end else if (bus.layer_en) begin
			if (bus.clr) begin
				acc <= prod;
			end else begin
				acc <= acc + prod;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/mac_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

interface mac_bus_if ();
	import fixed_point_pkg::*;

	// clr marks the first MAC cycle of a new pixel
	logic clr;
	logic layer_en;

	// pix and ker line up, both lag the tap counter by one clock
	pix_t pix;
	wgt_t ker [`DSP_NO];

	modport ctrl (output clr, output layer_en, output pix);

	modport rom (output ker);

	modport mac (input clr, input layer_en, input pix, input ker);

endinterface

`default_nettype wire

//--- logic/requant_relu.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

module requant_relu (
	input wire clk,
	input wire clr,
	input wire fixed_point_pkg::acc_t acc [`DSP_NO],
	output fixed_point_pkg::pix_t ofm [`DSP_NO]
);
	import fixed_point_pkg::*;

	// per-channel bias, already at accumulator scale
	localparam bias_t BIAS [`DSP_NO] = '{20'sd64, -20'sd32, 20'sd0, 20'sd128};
	localparam acc_t SAT_LIMIT = acc_t'(127);
	localparam pix_t PIX_MAX = 8'sd127;

	acc_t biased [`DSP_NO];
	acc_t scaled [`DSP_NO];

	always_comb begin
		for (int ch = 0; ch < `DSP_NO; ch++) begin
			biased[ch] = acc[ch] + BIAS[ch];
			scaled[ch] = biased[ch] >>> `FRAC;
		end
	end

	// the sums are final while clr is high; ReLU first, then saturate
	always_ff @(posedge clk) begin
		if (clr) begin
			for (int ch = 0; ch < `DSP_NO; ch++) begin
				if (biased[ch][`ACC_W-1]) begin
					ofm[ch] <= '0;
				end else if (scaled[ch] > SAT_LIMIT) begin
					ofm[ch] <= PIX_MAX;
				end else begin
					ofm[ch] <= pix_t'(scaled[ch]);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/squeeze_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

module squeeze_ctrl (
	input wire clk,
	input wire rst,
	input wire en,
	input wire fixed_point_pkg::pix_t ifm,
	input wire ram_feedback,
	mac_bus_if.ctrl bus,
	output layer_ctrl_pkg::tap_cnt_t tap_addr,
	output logic clr,
	output logic sample,
	output logic finish
);
	import layer_ctrl_pkg::*;

	localparam tap_cnt_t SPARE_TAP = tap_cnt_t'(`TAPS);
	localparam pix_cnt_t LAST_PIX = pix_cnt_t'(`WOUT * `WOUT - 1);

	ctrl_state_t state;
	pix_cnt_t pix_cnt;
	logic step;
	logic spare;
	logic fb_seen;

	// an enabled cycle only counts until the layer has ended
	assign step = en && (state != DONE);
	assign spare = (tap_addr == SPARE_TAP);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (en) state <= RUN;
				RUN: if (step && spare && pix_cnt == LAST_PIX) state <= DONE;
				default: state <= DONE;
			endcase
		end
	end

	// the tap counter doubles as the ROM address; the spare slot of a
	// pixel schedules clr for the following clock
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			tap_addr <= '0;
			pix_cnt <= '0;
			clr <= 1'b0;
		end else begin
			clr <= step && spare;
			if (step && spare) begin
				tap_addr <= '0;
				pix_cnt <= pix_cnt + 1'b1;
			end else if (step) begin
				tap_addr <= tap_addr + 1'b1;
			end
		end
	end

	// layer_en and sample are the one-clock delayed step and clr
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bus.layer_en <= 1'b0;
			sample <= 1'b0;
			fb_seen <= 1'b0;
		end else begin
			bus.layer_en <= step;
			sample <= clr;
			if (ram_feedback) fb_seen <= 1'b1;
		end
	end

	// pix is delayed to meet the registered ROM output
	always_ff @(posedge clk) begin
		bus.pix <= ifm;
	end

	assign bus.clr = clr;
	assign finish = (state == DONE) && !fb_seen;

endmodule

`default_nettype wire

//--- logic/squeeze_defines.svh
`ifndef SQUEEZE_DEFINES_SVH
`define SQUEEZE_DEFINES_SVH

// number of output channels computed in parallel, one MAC each
`define DSP_NO 4

// input channels and kernel side of the squeeze convolution
`define CHIN 8
`define KERNEL_DIM 1

// data values that make up one output pixel
`define TAPS (`KERNEL_DIM * `KERNEL_DIM * `CHIN)

// output feature map is WOUT x WOUT pixels
`define WOUT 2

// right shift that brings the accumulator back to feature scale
`define FRAC 6

// widths of the fixed-point words
`define PIX_W 8
`define WGT_W 8
`define ACC_W 20

`endif

//--- logic/squeeze_layer.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

module squeeze_layer (
	input wire clk,
	input wire rst,
	input wire en,
	input wire fixed_point_pkg::pix_t ifm,
	input wire ram_feedback,
	output logic sample,
	output logic finish,
	output fixed_point_pkg::pix_t ofm [`DSP_NO]
);
	import fixed_point_pkg::*;
	import layer_ctrl_pkg::*;

	mac_bus_if bus ();

	tap_cnt_t tap_addr;
	logic clr;
	acc_t acc [`DSP_NO];

	squeeze_ctrl i_squeeze_ctrl (
		.clk(clk),
		.rst(rst),
		.en(en),
		.ifm(ifm),
		.ram_feedback(ram_feedback),
		.bus(bus.ctrl),
		.tap_addr(tap_addr),
		.clr(clr),
		.sample(sample),
		.finish(finish)
	);

	weight_rom i_weight_rom (
		.clk(clk),
		.tap_addr(tap_addr),
		.bus(bus.rom)
	);

	// one MAC per output channel, each picks its own column of ker
	for (genvar ch = 0; ch < `DSP_NO; ch++) begin : g_mac
		mac i_mac (
			.clk(clk),
			.rst(rst),
			.bus(bus.mac),
			.idx(($clog2(`DSP_NO))'(ch)),
			.acc(acc[ch])
		);
	end

	requant_relu i_requant_relu (
		.clk(clk),
		.clr(clr),
		.acc(acc),
		.ofm(ofm)
	);

endmodule

`default_nettype wire

//--- logic/weight_rom.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

module weight_rom (
	input wire clk,
	input wire layer_ctrl_pkg::tap_cnt_t tap_addr,
	mac_bus_if.rom bus
);
	import layer_ctrl_pkg::*;

	// one row per tap, columns are the output channels 0 to 3
	// channel 1 leans negative and channel 3 is all positive so that
	// the requantizer sees both the zero floor and the upper clip
	always_ff @(posedge clk) begin
		case (tap_addr)
			tap_cnt_t'(0): begin
				bus.ker <= '{8'sd12, -8'sd7, 8'sd3, 8'sd25};
			end
			tap_cnt_t'(1): begin
				bus.ker <= '{-8'sd5, 8'sd9, -8'sd14, 8'sd18};
			end
			tap_cnt_t'(2): begin
				bus.ker <= '{8'sd20, -8'sd3, 8'sd6, 8'sd31};
			end
			tap_cnt_t'(3): begin
				bus.ker <= '{8'sd7, -8'sd16, 8'sd11, 8'sd22};
			end
			tap_cnt_t'(4): begin
				bus.ker <= '{-8'sd9, 8'sd4, -8'sd2, 8'sd27};
			end
			tap_cnt_t'(5): begin
				bus.ker <= '{8'sd15, -8'sd11, 8'sd8, 8'sd19};
			end
			tap_cnt_t'(6): begin
				bus.ker <= '{8'sd3, 8'sd6, -8'sd10, 8'sd24};
			end
			tap_cnt_t'(7): begin
				bus.ker <= '{-8'sd4, -8'sd13, 8'sd5, 8'sd29};
			end
			// the spare slot reads zero weights, so the clr cycle loads a
			// zero product and the next pixel starts from a clean sum
			default: begin
				bus.ker <= '{default: '0};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the squeeze layer testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project directory"
	exit 1
fi

BUILD_DIR=obj_dir
SIM_BIN=squeeze_layer_sim
LOG_FILE=sim.log

rm -rf "$BUILD_DIR" "$LOG_FILE"
if [ $? -ne 0 ]; then
	echo "cannot remove the previous build"
	exit 1
fi

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	-f flist.f --top-module squeeze_layer_tb \
	-Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

grep -qx "Test passed" "$LOG_FILE"
if [ $? -ne 0 ]; then
	echo "pass message not found in $LOG_FILE"
	exit 1
fi
exit 0

//--- verification/squeeze_layer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "squeeze_defines.svh"

module squeeze_layer_tb;
	import fixed_point_pkg::*;

	localparam int PIXELS = `WOUT * `WOUT;
	// one record holds the ifm values of a pixel followed by its expected ofm
	localparam int RECORD = `TAPS + `DSP_NO;
	localparam int FRAME = `TAPS + 1;
	localparam int BASE_CYCLES = PIXELS * FRAME + 40;
	localparam int TAIL_CYCLES = 10;
	localparam int FEEDBACK_WATCH = 8;

	logic clk;
	logic rst;
	logic en;
	pix_t ifm;
	logic ram_feedback;
	logic sample;
	logic finish;
	pix_t ofm [`DSP_NO];

	logic [7:0] testdata [PIXELS * RECORD];

	int data_errors;
	int ctrl_errors;
	int sample_count;
	int pause_cycles;

	squeeze_layer i_squeeze_layer (
		.clk(clk),
		.rst(rst),
		.en(en),
		.ifm(ifm),
		.ram_feedback(ram_feedback),
		.sample(sample),
		.finish(finish),
		.ofm(ofm)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// the allowed run length grows with every pause that the stimulus inserts
	initial begin
		int waited;
		waited = 0;
		while (waited <= BASE_CYCLES + pause_cycles) begin
			@(posedge clk);
			waited++;
		end
		$display("watchdog expired after %0d cycles without the run completing", waited);
		$display("Test failed");
		$finish;
	end

	function automatic pix_t random_pixel();
		return pix_t'($urandom);
	endfunction

	// inputs change on the falling edge only, the DUT samples them on the rising one
	task automatic drive(input logic en_val, input pix_t ifm_val);
		en = en_val;
		ifm = ifm_val;
		@(negedge clk);
	endtask

	task automatic expect_level(input string name, input logic value, input logic expected);
		if (value !== expected) begin
			ctrl_errors++;
			$display("** Error: %s is %h, expected %h at %0t", name, value, expected, $time);
		end
	endtask

	task automatic compare_pixel(input int pixel);
		pix_t expected;
		for (int ch = 0; ch < `DSP_NO; ch++) begin
			expected = pix_t'(testdata[pixel * RECORD + `TAPS + ch]);
			if (ofm[ch] !== expected) begin
				data_errors++;
				$display("** Error: ofm[%0d] of pixel %0d is %h, expected %h",
					ch, pixel, ofm[ch], expected);
			end
		end
	endtask

	// one pixel frame is TAPS data cycles and a spare cycle whose ifm is ignored.
	// a single pause of 1 to 3 cycles lands somewhere in the frame
	task automatic stream_pixel(input int pixel);
		int pause_at;
		int pause_len;
		pause_at = $urandom % FRAME;
		pause_len = 1 + $urandom % 3;
		for (int t = 0; t < FRAME; t++) begin
			// the layer is not over until the last spare slot has gone by
			expect_level("finish", finish, 1'b0);
			if (t == pause_at) begin
				pause_cycles += pause_len;
				repeat (pause_len) drive(1'b0, random_pixel());
			end
			if (t < `TAPS) begin
				drive(1'b1, pix_t'(testdata[pixel * RECORD + t]));
			end else begin
				drive(1'b1, random_pixel());
			end
		end
	endtask

	// ofm is only meaningful while sample is high, so every pulse is checked here
	always @(negedge clk) begin
		if (sample === 1'b1) begin
			if (sample_count < PIXELS) begin
				compare_pixel(sample_count);
			end else begin
				ctrl_errors++;
				$display("sample pulse %0d arrived after the layer had already ended",
					sample_count + 1);
			end
			sample_count++;
		end
	end

	initial begin
		void'($urandom(88));
		rst = 1'b0;
		en = 1'b0;
		ifm = '0;
		ram_feedback = 1'b0;
		data_errors = 0;
		ctrl_errors = 0;
		sample_count = 0;
		pause_cycles = 0;

		$readmemh("verification/squeeze_testdata.txt", testdata);
		if ($isunknown(testdata[0]) || $isunknown(testdata[PIXELS * RECORD - 1])) begin
			ctrl_errors++;
			$display("the test data file could not be read completely");
		end

		repeat (3) begin
			@(negedge clk);
			expect_level("sample", sample, 1'b0);
			expect_level("finish", finish, 1'b0);
		end
		rst = 1'b1;

		// out of reset but not enabled yet, nothing may happen
		repeat (4) begin
			drive(1'b0, '0);
			expect_level("sample", sample, 1'b0);
			expect_level("finish", finish, 1'b0);
		end

		for (int p = 0; p < PIXELS; p++) begin
			stream_pixel(p);
		end

		while (finish !== 1'b1) begin
			drive(1'b1, random_pixel());
		end

		// en stays high past the end, the last sample still comes out but no more after it
		repeat (TAIL_CYCLES) drive(1'b1, random_pixel());
		if (sample_count != PIXELS) begin
			ctrl_errors++;
			$display("expected %0d sample pulses but saw %0d", PIXELS, sample_count);
		end
		expect_level("finish", finish, 1'b1);

		// one-cycle acknowledge from the feature-map RAM clears finish for good
		ram_feedback = 1'b1;
		drive(1'b0, '0);
		ram_feedback = 1'b0;
		repeat (FEEDBACK_WATCH) begin
			expect_level("finish", finish, 1'b0);
			drive(1'b1, random_pixel());
		end

		$display("run complete with %0d data errors and %0d control errors, %0d pause cycles",
			data_errors, ctrl_errors, pause_cycles);
		if (data_errors + ctrl_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/squeeze_testdata.txt
// one record per output pixel, all values are 8-bit two's complement in hex
// first line of a record holds ifm for taps 0 to 7, second line expected ofm for channels 0 to 3

// pixel 0, rising ramp, channel 1 goes negative and channel 3 clips
0a 14 1e 28 32 3c 46 50
14 00 07 7f

// pixel 1, mixed signs, channels 2 and 3 fall below zero
ec 05 f8 0f e2 0c 28 e7
06 03 00 00

// pixel 2, full-scale values of both signs
7f 80 40 c0 64 9c 01 ff
0a 04 0d 25

// pixel 3, every input at -128, only channel 1 stays positive
80 80 80 80 80 80 80 80
00 3d 00 00
